/* logic/scaler_pkg.sv */
package scaler_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and fixed-point constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PIXEL_WIDTH = 12;
    localparam int COE_WIDTH   = 10;
    localparam int COE_FRAC    = 8;                          // Coefficient fraction bits
    localparam int COE_UNITY   = 1 << COE_FRAC;
    localparam int COE_HALF    = COE_UNITY / 2;
    localparam int PIXEL_STEP  = 4096;                       // 1.0 in 4.12
    localparam int STEP_WIDTH  = 16;
    localparam int POS_WIDTH   = 24;
    localparam int POS_FRAC    = $clog2(PIXEL_STEP);
    localparam int PHASE_WIDTH = 10;
    localparam int PHASE_SIZE  = 1 << PHASE_WIDTH;
    localparam int MUL_WIDTH   = PIXEL_WIDTH + COE_WIDTH;
    localparam int SUM_WIDTH   = MUL_WIDTH + 2;              // Sign plus headroom
    localparam int ROUND_ADD   = 1 << (COE_FRAC - 1);
    localparam int TAP_NUM     = 4;
    localparam int SYNC_DELAY  = 3;                          // Strobe stages before output reg

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [TAP_NUM-1:0][COE_WIDTH-1:0] coe_vec_t;

    localparam pixel_t PIX_MAX = '1;

    typedef enum logic [1:0] {
        TAP_FAR_LEFT  = 2'd0,
        TAP_LEFT      = 2'd1,
        TAP_RIGHT     = 2'd2,
        TAP_FAR_RIGHT = 2'd3
    } tap_e;

    // Keys kernel, a = -0.5, magnitude scaled to COE_UNITY
    function automatic logic [COE_WIDTH-1:0] cubic_weight(input int unsigned phase,
                                                          input tap_e tap);
        longint p;
        longint q;
        longint one;
        longint num;
        p   = longint'(phase);
        one = longint'(PHASE_SIZE);
        q   = one - p;
        case (tap)
            TAP_FAR_LEFT:  num = COE_HALF * p * q * q;
            TAP_LEFT:      num = 3 * COE_HALF * p * p * p - 5 * COE_HALF * p * p * one
                                 + COE_UNITY * one * one * one;
            TAP_RIGHT:     num = -3 * COE_HALF * p * p * p + 4 * COE_HALF * p * p * one
                                 + COE_HALF * p * one * one;
            TAP_FAR_RIGHT: num = COE_HALF * p * p * q;
            default:       num = 0;
        endcase
        num = num + (longint'(1) <<< (3 * PHASE_WIDTH - 1));  // Round to nearest
        return COE_WIDTH'(num >>> (3 * PHASE_WIDTH));
    endfunction

endpackage

/* logic/video_if.sv */
`timescale 1ns/1ps

// Single pixel stream with level de and first-pixel strobes
interface video_if;

    scaler_pkg::pixel_t pix;
    logic               de;
    logic               hs;                  // First pixel of a line
    logic               vs;                  // First pixel of a frame

    modport source (
        output pix,
        output de,
        output hs,
        output vs
    );

    modport sink (
        input pix,
        input de,
        input hs,
        input vs
    );

endinterface

/* logic/cubic_table.sv */
`timescale 1ns/1ps

module cubic_table (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [scaler_pkg::PHASE_WIDTH-1:0]  phase_i,
    output scaler_pkg::coe_vec_t                coe_o
);

    scaler_pkg::coe_vec_t                    rom [scaler_pkg::PHASE_SIZE];
    logic                                    rd_valid;
    logic signed [scaler_pkg::COE_WIDTH+1:0] coe_net;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ROM contents, constant at elaboration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar ph = 0; ph < scaler_pkg::PHASE_SIZE; ph++) begin : g_phase
        for (genvar t = 0; t < scaler_pkg::TAP_NUM; t++) begin : g_tap
            assign rom[ph][t] = scaler_pkg::cubic_weight(ph, scaler_pkg::tap_e'(t));
        end
    end

    always_ff @(posedge clk) begin
        coe_o <= rom[phase_i];                   // Registered read
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b1;                    // coe_o holds a real entry
        end
    end

    // Inner taps add, outer taps subtract
    assign coe_net = $signed({2'b00, coe_o[scaler_pkg::TAP_LEFT]})
                   + $signed({2'b00, coe_o[scaler_pkg::TAP_RIGHT]})
                   - $signed({2'b00, coe_o[scaler_pkg::TAP_FAR_LEFT]})
                   - $signed({2'b00, coe_o[scaler_pkg::TAP_FAR_RIGHT]});

    a_unity_gain: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        rd_valid |-> (coe_net >= scaler_pkg::COE_UNITY - 2)
                  && (coe_net <= scaler_pkg::COE_UNITY + 2)
    ) else $error("[ERROR] %0t coe_net %0d expected %0d +-2",
                  $time, coe_net, scaler_pkg::COE_UNITY);

endmodule

/* logic/scaler_h.sv */
`timescale 1ns/1ps

module scaler_h (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic [scaler_pkg::STEP_WIDTH-1:0]  scale_step_i,
    video_if.sink                              vid_in,
    video_if.source                            vid_out
);

    scaler_pkg::pixel_t                             win [scaler_pkg::TAP_NUM];
    scaler_pkg::pixel_t                             tap_q [scaler_pkg::TAP_NUM];
    logic [scaler_pkg::POS_WIDTH-1:0]               pos_i;
    logic [scaler_pkg::POS_WIDTH-1:0]               pos_o;
    logic [scaler_pkg::PHASE_WIDTH-1:0]             phase;
    logic                                           decide;
    logic                                           sol_q;
    logic                                           sof_q;
    scaler_pkg::coe_vec_t                           coe;
    logic [scaler_pkg::MUL_WIDTH-1:0]               prod_q [scaler_pkg::TAP_NUM];
    logic signed [scaler_pkg::SUM_WIDTH-1:0]        sum_q;
    scaler_pkg::pixel_t                             pix_d;
    logic [2:0]                                     strb_new;
    logic [scaler_pkg::SYNC_DELAY-1:0][2:0]         strb_sr;
    scaler_pkg::pixel_t                             pix_q;
    logic                                           de_q;
    logic                                           hs_q;
    logic                                           vs_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input window and position accumulators
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (vid_in.de) begin
            win[0] <= vid_in.pix;                // win[0] is the newest pixel
            for (int i = 1; i < scaler_pkg::TAP_NUM; i++) begin
                win[i] <= win[i-1];
            end
        end
    end

    assign decide = (pos_i > pos_o);
    assign phase  = pos_o[scaler_pkg::POS_FRAC-1 -: scaler_pkg::PHASE_WIDTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pos_i <= '0;
            pos_o <= '0;
            sol_q <= 1'b0;
            sof_q <= 1'b0;
        end else begin
            if (vid_in.de) begin
                pos_i <= pos_i + scaler_pkg::POS_WIDTH'(scaler_pkg::PIXEL_STEP);
            end
            if (decide) begin
                pos_o <= pos_o + scaler_pkg::POS_WIDTH'(scale_step_i);
            end
            if (vid_in.de && vid_in.hs) begin
                pos_i <= '0;                         // Line restarts both positions
                pos_o <= scaler_pkg::POS_WIDTH'(scaler_pkg::PIXEL_STEP);
            end

            if (vid_in.de && vid_in.hs) begin
                sol_q <= 1'b1;
            end else if (decide) begin
                sol_q <= 1'b0;
            end
            if (vid_in.de && vid_in.vs) begin
                sof_q <= 1'b1;
            end else if (decide) begin
                sof_q <= 1'b0;
            end
        end
    end

    // Window snapshot, aligned with the table read
    always_ff @(posedge clk) begin
        if (decide) begin
            tap_q[scaler_pkg::TAP_FAR_RIGHT] <= win[0];
            tap_q[scaler_pkg::TAP_RIGHT]     <= win[1];
            tap_q[scaler_pkg::TAP_LEFT]      <= win[2];
            // No pixel left of the line start yet
            tap_q[scaler_pkg::TAP_FAR_LEFT]  <=
                (pos_i <= scaler_pkg::POS_WIDTH'(2 * scaler_pkg::PIXEL_STEP)) ? '0 : win[3];
        end
    end

    cubic_table i_cubic_table (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .phase_i (phase),
        .coe_o   (coe)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiply, sum and clamp
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        for (int t = 0; t < scaler_pkg::TAP_NUM; t++) begin
            prod_q[t] <= coe[t] * tap_q[t];
        end
        sum_q <= $signed({2'b00, prod_q[scaler_pkg::TAP_LEFT]})
               + $signed({2'b00, prod_q[scaler_pkg::TAP_RIGHT]})
               - $signed({2'b00, prod_q[scaler_pkg::TAP_FAR_LEFT]})
               - $signed({2'b00, prod_q[scaler_pkg::TAP_FAR_RIGHT]})
               + scaler_pkg::SUM_WIDTH'(scaler_pkg::ROUND_ADD);
    end

    always_comb begin
        if (sum_q < 0) begin
            pix_d = '0;                              // Undershoot
        end else if (sum_q[scaler_pkg::SUM_WIDTH-2:
                           scaler_pkg::COE_FRAC+scaler_pkg::PIXEL_WIDTH] != '0) begin
            pix_d = scaler_pkg::PIX_MAX;             // Overshoot
        end else begin
            pix_d = sum_q[scaler_pkg::COE_FRAC +: scaler_pkg::PIXEL_WIDTH];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe alignment and output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign strb_new = {decide & sof_q, decide & sol_q, decide};  // {vs, hs, de}

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            strb_sr <= '0;
            pix_q   <= '0;
            de_q    <= 1'b0;
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
        end else begin
            strb_sr[0] <= strb_new;
            for (int i = 1; i < scaler_pkg::SYNC_DELAY; i++) begin
                strb_sr[i] <= strb_sr[i-1];
            end
            de_q <= strb_sr[scaler_pkg::SYNC_DELAY-1][0];
            hs_q <= strb_sr[scaler_pkg::SYNC_DELAY-1][1];
            vs_q <= strb_sr[scaler_pkg::SYNC_DELAY-1][2];
            if (strb_sr[scaler_pkg::SYNC_DELAY-1][0]) begin
                pix_q <= pix_d;                      // Hold last value between strobes
            end
        end
    end

    assign vid_out.pix = pix_q;
    assign vid_out.de  = de_q;
    assign vid_out.hs  = hs_q;
    assign vid_out.vs  = vs_q;

    a_no_de_in_reset: assert property (
        @(posedge clk) !rst_n_i |-> !vid_out.de
    ) else $error("[ERROR] %0t de_o %b expected 0 in reset", $time, vid_out.de);

    a_hs_with_de: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        vid_out.hs |-> vid_out.de
    ) else $error("[ERROR] %0t hs_o %b with de_o %b", $time, vid_out.hs, vid_out.de);

    // Table read, multiply, sum, output register
    a_decide_latency: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        decide |-> ##4 vid_out.de
    ) else $error("[ERROR] %0t de_o %b expected 1 four cycles after decision",
                  $time, vid_out.de);

endmodule

/* logic/scaler_top.sv */
`timescale 1ns/1ps

module scaler_top (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic [scaler_pkg::STEP_WIDTH-1:0]  scale_step_i,   // 4.12, 4096 is 1.0
    input  scaler_pkg::pixel_t                 pix_i,
    input  logic                               de_i,
    input  logic                               hs_i,
    input  logic                               vs_i,
    output scaler_pkg::pixel_t                 pix_o,
    output logic                               de_o,
    output logic                               hs_o,
    output logic                               vs_o
);

    video_if vid_in ();
    video_if vid_out ();

    assign vid_in.pix = pix_i;
    assign vid_in.de  = de_i;
    assign vid_in.hs  = hs_i;
    assign vid_in.vs  = vs_i;

    scaler_h i_scaler_h (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .scale_step_i (scale_step_i),
        .vid_in       (vid_in.sink),
        .vid_out      (vid_out.source)
    );

    assign pix_o = vid_out.pix;
    assign de_o  = vid_out.de;                 // One strobe per output pixel
    assign hs_o  = vid_out.hs;
    assign vs_o  = vid_out.vs;

endmodule

/* tests/tb_scaler_top.sv */
`timescale 1ns/1ps

module tb_scaler_top;

    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int unsigned SEED         = 32'ha85ee4c6;
    localparam int          ID_LINES     = 6;
    localparam int          FLAT_LINES   = 8;
    localparam int          CLAMP_LINES  = 4;
    localparam int          CLAMP_STEP   = 1536;
    localparam int          LINE_MAX     = 64 + 3 * 64 + 24;   // Pixels, drain, idle
    localparam int          STIM_CYCLES  = RESET_CYCLES + 8
                                         + (ID_LINES + FLAT_LINES + CLAMP_LINES) * LINE_MAX;
    localparam int          WATCHDOG_NS  = (STIM_CYCLES * 2 + 200) * 2 * CLK_HALF;
    localparam int          MODE_ID      = 0;
    localparam int          MODE_FLAT    = 1;
    localparam int          MODE_CLAMP   = 2;

    logic                               clk;
    logic                               rst_n_i;
    logic [scaler_pkg::STEP_WIDTH-1:0]  scale_step_i;
    scaler_pkg::pixel_t                 pix_i;
    logic                               de_i;
    logic                               hs_i;
    logic                               vs_i;
    scaler_pkg::pixel_t                 pix_o;
    logic                               de_o;
    logic                               hs_o;
    logic                               vs_o;

    int                                 mode;
    int                                 flat_value;
    int                                 clamp_start;
    scaler_pkg::pixel_t                 exp_pix_q [$];
    scaler_pkg::pixel_t                 exp_pix;
    int                                 diff;
    int                                 out_cnt;
    int                                 hs_cnt;
    int                                 vs_cnt;
    int                                 rel_cnt;                // Negedges since reset release
    int                                 zero_cnt;
    int                                 max_cnt;
    int unsigned                        seed_ret;

    scaler_top i_scaler_top (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .scale_step_i (scale_step_i),
        .pix_i        (pix_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .pix_o        (pix_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic wrong_value(input string sig, input int got, input int want);
        $display("[ERROR] %0t %s got %0d expected %0d", $time, sig, got, want);
        stop_failed();
    endtask

    task automatic broken_rule(input string what);
        $display("[ERROR] %0t %s", $time, what);
        stop_failed();
    endtask

    // Output positions that stay left of the last input pixel
    function automatic int expected_outputs(input int n, input int step);
        int k;
        k = 0;
        while (scaler_pkg::PIXEL_STEP + k * step < (n - 1) * scaler_pkg::PIXEL_STEP) begin
            k++;
        end
        return k;
    endfunction

    task automatic send_line(input int n, input int step, input bit with_vs);
        int                 exp_cnt;
        scaler_pkg::pixel_t value;
        exp_cnt = expected_outputs(n, step);
        out_cnt = 0;
        hs_cnt  = 0;
        vs_cnt  = 0;
        exp_pix_q.delete();
        @(posedge clk);
        scale_step_i <= scaler_pkg::STEP_WIDTH'(step);
        for (int i = 0; i < n; i++) begin
            case (mode)
                MODE_FLAT:  value = scaler_pkg::pixel_t'(flat_value);
                MODE_CLAMP: value = ((i + clamp_start) % 2 != 0) ? scaler_pkg::PIX_MAX : '0;
                default:    value = scaler_pkg::pixel_t'($urandom);
            endcase
            exp_pix_q.push_back(value);
            @(posedge clk);
            pix_i <= value;
            de_i  <= 1'b1;
            hs_i  <= (i == 0);                                 // Strobes ride on the first pixel
            vs_i  <= with_vs && (i == 0);
        end
        @(posedge clk);
        de_i <= 1'b0;
        hs_i <= 1'b0;
        vs_i <= 1'b0;
        repeat (exp_cnt + 8 + $urandom_range(15, 0)) @(posedge clk);  // At most one decision per cycle
        assert (out_cnt == exp_cnt) else wrong_value("de_o count", out_cnt, exp_cnt);
        assert (hs_cnt == 1) else wrong_value("hs_o count", hs_cnt, 1);
        assert (vs_cnt == int'(with_vs)) else wrong_value("vs_o count", vs_cnt, int'(with_vs));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst_n_i || rel_cnt < 4) begin
            assert (!de_o) else wrong_value("de_o", int'(de_o), 0);
            assert (!hs_o) else wrong_value("hs_o", int'(hs_o), 0);
            assert (!vs_o) else wrong_value("vs_o", int'(vs_o), 0);
            assert (pix_o == '0) else wrong_value("pix_o", int'(pix_o), 0);
        end
        if (rst_n_i && rel_cnt < 4) begin
            rel_cnt++;
        end
        if (de_o) begin
            out_cnt++;
            case (mode)
                MODE_ID: begin
                    assert (exp_pix_q.size() > 0) else broken_rule("de_o with no input pixel left");
                    exp_pix = exp_pix_q.pop_front();
                    assert (pix_o == exp_pix) else wrong_value("pix_o", int'(pix_o), int'(exp_pix));
                end
                MODE_FLAT: begin
                    // Second output of an enlarged line still sees a zero far-left tap
                    if (out_cnt != 2 || scale_step_i >= scaler_pkg::PIXEL_STEP) begin
                        diff = int'(pix_o) - flat_value;
                        assert (diff >= -1 && diff <= 1)
                            else wrong_value("pix_o", int'(pix_o), flat_value);
                    end
                end
                default: begin
                    assert (int'(pix_o) >= 0 && int'(pix_o) <= int'(scaler_pkg::PIX_MAX))
                        else broken_rule("pix_o left the range 0 to full scale");
                    if (pix_o == '0) zero_cnt++;
                    if (pix_o == scaler_pkg::PIX_MAX) max_cnt++;
                end
            endcase
            if (out_cnt == 1) begin
                assert (hs_o) else wrong_value("hs_o", int'(hs_o), 1);  // First pixel of a line
            end
        end
        if (hs_o) begin
            hs_cnt++;
            assert (de_o) else wrong_value("de_o", int'(de_o), 1);
        end
        if (vs_o) begin
            vs_cnt++;
            assert (hs_o && de_o) else broken_rule("vs_o away from the first pixel of a line");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        broken_rule("watchdog expired before the tests finished");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed_ret     = $urandom(SEED);
        rst_n_i      = 1'b0;
        scale_step_i = scaler_pkg::STEP_WIDTH'(scaler_pkg::PIXEL_STEP);
        pix_i        = '0;
        de_i         = 1'b0;
        hs_i         = 1'b0;
        vs_i         = 1'b0;
        mode         = MODE_ID;
        flat_value   = 0;
        clamp_start  = 0;
        out_cnt      = 0;
        hs_cnt       = 0;
        vs_cnt       = 0;
        rel_cnt      = 0;
        zero_cnt     = 0;
        max_cnt      = 0;

        // Zero phase selects the left tap alone
        assert (scaler_pkg::cubic_weight(0, scaler_pkg::TAP_LEFT) == scaler_pkg::COE_UNITY)
            else broken_rule("left coefficient at phase zero is not unity");
        assert (scaler_pkg::cubic_weight(0, scaler_pkg::TAP_FAR_LEFT) == 0)
            else broken_rule("far-left coefficient at phase zero is not zero");
        assert (scaler_pkg::cubic_weight(0, scaler_pkg::TAP_RIGHT) == 0)
            else broken_rule("right coefficient at phase zero is not zero");
        assert (scaler_pkg::cubic_weight(0, scaler_pkg::TAP_FAR_RIGHT) == 0)
            else broken_rule("far-right coefficient at phase zero is not zero");

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (8) @(posedge clk);

        mode = MODE_ID;
        for (int l = 0; l < ID_LINES; l++) begin
            send_line($urandom_range(64, 16), scaler_pkg::PIXEL_STEP, l == 0);
        end

        mode = MODE_FLAT;
        for (int l = 0; l < FLAT_LINES; l++) begin
            flat_value = $urandom_range(127, 0);   // Two-LSB table error stays under one output LSB
            send_line($urandom_range(64, 16), $urandom_range(8192, 2048), l == 0);
        end

        mode = MODE_CLAMP;
        for (int l = 0; l < CLAMP_LINES; l++) begin
            clamp_start = l % 2;
            send_line($urandom_range(64, 16), CLAMP_STEP, l == 0);
        end
        assert (zero_cnt > 0) else broken_rule("no output clamped to zero");
        assert (max_cnt > 0) else broken_rule("no output clamped to full scale");

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* compile.f */
logic/scaler_pkg.sv
logic/video_if.sv
logic/cubic_table.sv
logic/scaler_h.sv
logic/scaler_top.sv
tests/tb_scaler_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then search the log for the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_scaler_top \
    -f compile.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_scaler_top > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
